/* common/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROM_ADDR_W = 8;    // Instruction word address
    localparam int RAM_WORDS  = 64;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);
    localparam int PWM_W      = 8;
    localparam int LED_W      = 6;
    localparam int LED_REG    = 31;   // Register mirrored on the LEDs

    // Address map: top three bits pick the device
    localparam logic [2:0] DEV_RAM = 3'b000;
    localparam logic [2:0] DEV_PWM = 3'b001;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

endpackage

/* pipeline/fetch.sv */
`timescale 1ns/1ps

module fetch import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic                  stall,
    input  logic                  branch_taken,
    input  logic [XLEN-1:0]       branch_target,
    input  logic [XLEN-1:0]       rom_data,
    output logic [ROM_ADDR_W-1:0] rom_address,
    output logic [XLEN-1:0]       pc,
    output logic [XLEN-1:0]       instr,
    output logic                  valid
);

    logic [XLEN-1:0] fetch_pc;

    assign rom_address = fetch_pc[ROM_ADDR_W+1:2];  // Word addressed ROM

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_pc <= '0;
            valid    <= 1'b0;
        end else if (enable) begin
            if (branch_taken) begin
                fetch_pc <= branch_target;
                valid    <= 1'b0;           // Squash the wrong-path fetch
            end else if (!stall) begin
                fetch_pc <= fetch_pc + 32'd4;
                valid    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable && !branch_taken && !stall) begin
            pc    <= fetch_pc;
            instr <= rom_data;
        end
    end

endmodule

/* pipeline/decode.sv */
`timescale 1ns/1ps

module decode import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [XLEN-1:0]       instr,
    input  logic [XLEN-1:0]       pc,
    input  logic                  valid,
    input  logic [XLEN-1:0]       value1,
    input  logic [XLEN-1:0]       value2,
    input  logic                  branch_taken,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic                  stall,
    output logic [XLEN-1:0]       imm,
    output alu_op_t               alu_op,
    output logic                  alu_src,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  reg_write,
    output logic [REG_ADDR_W-1:0] reg_dest,
    output logic                  branch,
    output logic                  branch_ne,
    output logic [XLEN-1:0]       pc_out,
    output logic [REG_ADDR_W-1:0] rs1_out,
    output logic [REG_ADDR_W-1:0] rs2_out,
    output logic [XLEN-1:0]       value1_out,
    output logic [XLEN-1:0]       value2_out,
    output logic                  de_valid
);

    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] dec_imm;
    alu_op_t         dec_alu_op;
    logic            dec_alu_src, dec_mem_read, dec_mem_write, dec_reg_write, dec_branch;

    function automatic alu_op_t funct_alu(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  funct_alu = sub ? ALU_SUB : ALU_ADD;
            3'b010:  funct_alu = ALU_SLT;
            3'b100:  funct_alu = ALU_XOR;
            3'b110:  funct_alu = ALU_OR;
            3'b111:  funct_alu = ALU_AND;
            default: funct_alu = ALU_ADD;
        endcase
    endfunction

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Load in execute whose result is needed here
    assign stall = mem_read && reg_dest != '0 && (reg_dest == rs1 || reg_dest == rs2);

    always_comb begin
        dec_imm       = {{20{instr[31]}}, instr[31:20]};  // I-type
        dec_alu_op    = ALU_ADD;
        dec_alu_src   = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_reg_write = 1'b0;
        dec_branch    = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_alu_op    = funct_alu(funct3, instr[30]);
                dec_reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_alu_op    = funct_alu(funct3, 1'b0);
                dec_alu_src   = 1'b1;
                dec_reg_write = 1'b1;
            end
            OPC_LOAD: begin
                dec_alu_src   = 1'b1;
                dec_mem_read  = 1'b1;
                dec_reg_write = 1'b1;
            end
            OPC_STORE: begin
                dec_imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec_alu_src   = 1'b1;
                dec_mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                dec_imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
                dec_branch = 1'b1;
            end
            default: ;  // Unsupported opcode acts as a NOP
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_valid  <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
            branch    <= 1'b0;
        end else if (enable) begin
            if (branch_taken || stall || !valid) begin  // Bubble
                de_valid  <= 1'b0;
                mem_read  <= 1'b0;
                mem_write <= 1'b0;
                reg_write <= 1'b0;
                branch    <= 1'b0;
            end else begin
                de_valid  <= 1'b1;
                mem_read  <= dec_mem_read;
                mem_write <= dec_mem_write;
                reg_write <= dec_reg_write;
                branch    <= dec_branch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            imm        <= dec_imm;
            alu_op     <= dec_alu_op;
            alu_src    <= dec_alu_src;
            reg_dest   <= instr[11:7];
            branch_ne  <= funct3[0];    // BNE has funct3 001
            pc_out     <= pc;
            rs1_out    <= rs1;
            rs2_out    <= rs2;
            value1_out <= value1;
            value2_out <= value2;
        end
    end

endmodule

/* pipeline/execute.sv */
`timescale 1ns/1ps

module execute import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [XLEN-1:0]       imm,
    input  alu_op_t               alu_op,
    input  logic                  alu_src,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  reg_write,
    input  logic [REG_ADDR_W-1:0] reg_dest,
    input  logic                  branch,
    input  logic                  branch_ne,
    input  logic [XLEN-1:0]       pc,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [XLEN-1:0]       value1,
    input  logic [XLEN-1:0]       value2,
    input  logic                  de_valid,
    input  logic                  mem_wb_reg_write,
    input  logic [REG_ADDR_W-1:0] mem_wb_reg_dest,
    input  logic [XLEN-1:0]       mem_wb_value,
    output logic                  branch_taken,
    output logic [XLEN-1:0]       branch_target,
    output logic [XLEN-1:0]       ex_mem_result,
    output logic [XLEN-1:0]       ex_mem_store_value,
    output logic                  ex_mem_mem_read,
    output logic                  ex_mem_mem_write,
    output logic                  ex_mem_reg_write,
    output logic [REG_ADDR_W-1:0] ex_mem_reg_dest
);

    logic [XLEN-1:0] op_a, fwd_b, op_b, alu_result;

    // Newest producer first, x0 never forwarded
    always_comb begin
        if (ex_mem_reg_write && ex_mem_reg_dest != '0 && ex_mem_reg_dest == rs1)
            op_a = ex_mem_result;
        else if (mem_wb_reg_write && mem_wb_reg_dest != '0 && mem_wb_reg_dest == rs1)
            op_a = mem_wb_value;
        else
            op_a = value1;
        if (ex_mem_reg_write && ex_mem_reg_dest != '0 && ex_mem_reg_dest == rs2)
            fwd_b = ex_mem_result;
        else if (mem_wb_reg_write && mem_wb_reg_dest != '0 && mem_wb_reg_dest == rs2)
            fwd_b = mem_wb_value;
        else
            fwd_b = value2;
    end

    assign op_b = alu_src ? imm : fwd_b;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    assign branch_taken  = de_valid && branch && ((op_a == fwd_b) != branch_ne);
    assign branch_target = pc + imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            ex_mem_reg_write <= 1'b0;
        end else if (enable) begin
            ex_mem_mem_read  <= mem_read;
            ex_mem_mem_write <= mem_write;
            ex_mem_reg_write <= reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            ex_mem_result      <= alu_result;   // Also the load/store address
            ex_mem_store_value <= fwd_b;
            ex_mem_reg_dest    <= reg_dest;
        end
    end

endmodule

/* pipeline/memory.sv */
`timescale 1ns/1ps

module memory import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [XLEN-1:0]       ex_mem_result,
    input  logic [XLEN-1:0]       ex_mem_store_value,
    input  logic                  ex_mem_mem_read,
    input  logic                  ex_mem_mem_write,
    input  logic                  ex_mem_reg_write,
    input  logic [REG_ADDR_W-1:0] ex_mem_reg_dest,
    input  logic [XLEN-1:0]       ram_data_out,
    output logic [RAM_ADDR_W-1:0] mem_addr,
    output logic [XLEN-1:0]       mem_write_data,
    output logic                  ram_write_enable,
    output logic                  pwm_write_enable,
    output logic                  mem_wb_reg_write,
    output logic [REG_ADDR_W-1:0] mem_wb_reg_dest,
    output logic [XLEN-1:0]       mem_wb_value
);

    logic [2:0]      device;
    logic [XLEN-1:0] load_data;

    assign device         = ex_mem_result[XLEN-1:XLEN-3];
    assign mem_addr       = ex_mem_result[RAM_ADDR_W+1:2];
    assign mem_write_data = ex_mem_store_value;

    // RAM qualifies its own write with enable
    assign ram_write_enable = ex_mem_mem_write && device == DEV_RAM;
    assign pwm_write_enable = ex_mem_mem_write && device == DEV_PWM && enable;

    assign load_data = (device == DEV_RAM) ? ram_data_out : '0;  // PWM reads as zero

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mem_wb_reg_write <= 1'b0;
        else if (enable)
            mem_wb_reg_write <= ex_mem_reg_write;
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            mem_wb_reg_dest <= ex_mem_reg_dest;
            mem_wb_value    <= ex_mem_mem_read ? load_data : ex_mem_result;
        end
    end

endmodule

/* hdl/register_bank.sv */
`timescale 1ns/1ps

module register_bank import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic                  write_enable,
    input  logic [REG_ADDR_W-1:0] write_address,
    input  logic [XLEN-1:0]       write_value,
    input  logic [REG_ADDR_W-1:0] read_address1,
    input  logic [REG_ADDR_W-1:0] read_address2,
    output logic [XLEN-1:0]       value1,
    output logic [XLEN-1:0]       value2,
    output logic [LED_W-1:0]      led
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_valid;

    assign wr_valid = write_enable && write_address != '0;  // x0 stays zero

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
                regs[i] <= '0;
        end else if (enable && wr_valid) begin
            regs[write_address] <= write_value;
        end
    end

    // Write-through so decode sees the value being written back
    assign value1 = (read_address1 == '0) ? '0 :
                    (wr_valid && write_address == read_address1) ? write_value :
                    regs[read_address1];
    assign value2 = (read_address2 == '0) ? '0 :
                    (wr_valid && write_address == read_address2) ? write_value :
                    regs[read_address2];

    assign led = regs[LED_REG][LED_W-1:0];

endmodule

/* hdl/ram.sv */
`timescale 1ns/1ps

module ram import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  enable,
    input  logic [RAM_ADDR_W-1:0] address,
    input  logic [XLEN-1:0]       data_in,
    input  logic                  write_enable,
    output logic [XLEN-1:0]       data_out
);

    logic [XLEN-1:0] mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (enable && write_enable)
            mem[address] <= data_in;
    end

    assign data_out = mem[address];  // Same-cycle read for the load path

endmodule

/* hdl/pwm_peripheral.sv */
`timescale 1ns/1ps

module pwm_peripheral import cpu_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             write_enable,
    input  logic [PWM_W-1:0] duty_in,
    output logic             pwm_out
);

    logic [PWM_W-1:0] duty;
    logic [PWM_W-1:0] counter;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            duty    <= '0;
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;  // Free running, wraps every 256 clocks
            if (write_enable)
                duty <= duty_in;
        end
    end

    assign pwm_out = counter < duty;

endmodule

/* hdl/cpu.sv */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [XLEN-1:0]       rom_data,
    output logic [ROM_ADDR_W-1:0] rom_address,
    output logic [LED_W-1:0]      led,
    output logic                  port_pwm1
);

    // Fetch -> Decode
    logic [XLEN-1:0] if_de_pc, if_de_instr;
    logic            if_de_valid;

    // Decode <-> Register bank
    logic [REG_ADDR_W-1:0] rb_read_address1, rb_read_address2;
    logic [XLEN-1:0]       rb_value1, rb_value2;

    // Decode -> Execute
    logic [XLEN-1:0]       de_ex_imm, de_ex_pc, de_ex_value1, de_ex_value2;
    alu_op_t               de_ex_alu_op;
    logic                  de_ex_alu_src, de_ex_mem_read, de_ex_mem_write;
    logic                  de_ex_reg_write, de_ex_branch, de_ex_branch_ne, de_ex_valid;
    logic [REG_ADDR_W-1:0] de_ex_reg_dest, de_ex_rs1, de_ex_rs2;

    // Hazard and branch control
    logic            stall, branch_taken;
    logic [XLEN-1:0] branch_target;

    // Execute -> Memory
    logic [XLEN-1:0]       ex_mem_result, ex_mem_store_value;
    logic                  ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write;
    logic [REG_ADDR_W-1:0] ex_mem_reg_dest;

    // Memory -> Register bank and forwarding
    logic                  mem_wb_reg_write;
    logic [REG_ADDR_W-1:0] mem_wb_reg_dest;
    logic [XLEN-1:0]       mem_wb_value;

    // Memory stage <-> devices
    logic [RAM_ADDR_W-1:0] mem_addr;
    logic [XLEN-1:0]       mem_write_data, ram_data_out;
    logic                  ram_write_enable, pwm_write_enable;

    fetch u_fetch (
        .clk(clock), .arst_n(arst_n), .enable(enable),
        .stall(stall), .branch_taken(branch_taken), .branch_target(branch_target),
        .rom_data(rom_data), .rom_address(rom_address),
        .pc(if_de_pc), .instr(if_de_instr), .valid(if_de_valid)
    );

    decode u_decode (
        .clk(clock), .arst_n(arst_n), .enable(enable),
        .instr(if_de_instr), .pc(if_de_pc), .valid(if_de_valid),
        .value1(rb_value1), .value2(rb_value2), .branch_taken(branch_taken),
        .rs1(rb_read_address1), .rs2(rb_read_address2), .stall(stall),
        .imm(de_ex_imm), .alu_op(de_ex_alu_op), .alu_src(de_ex_alu_src),
        .mem_read(de_ex_mem_read), .mem_write(de_ex_mem_write),
        .reg_write(de_ex_reg_write), .reg_dest(de_ex_reg_dest),
        .branch(de_ex_branch), .branch_ne(de_ex_branch_ne), .pc_out(de_ex_pc),
        .rs1_out(de_ex_rs1), .rs2_out(de_ex_rs2),
        .value1_out(de_ex_value1), .value2_out(de_ex_value2), .de_valid(de_ex_valid)
    );

    execute u_execute (
        .clk(clock), .arst_n(arst_n), .enable(enable),
        .imm(de_ex_imm), .alu_op(de_ex_alu_op), .alu_src(de_ex_alu_src),
        .mem_read(de_ex_mem_read), .mem_write(de_ex_mem_write),
        .reg_write(de_ex_reg_write), .reg_dest(de_ex_reg_dest),
        .branch(de_ex_branch), .branch_ne(de_ex_branch_ne), .pc(de_ex_pc),
        .rs1(de_ex_rs1), .rs2(de_ex_rs2), .value1(de_ex_value1), .value2(de_ex_value2),
        .de_valid(de_ex_valid),
        .mem_wb_reg_write(mem_wb_reg_write), .mem_wb_reg_dest(mem_wb_reg_dest),
        .mem_wb_value(mem_wb_value),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .ex_mem_result(ex_mem_result), .ex_mem_store_value(ex_mem_store_value),
        .ex_mem_mem_read(ex_mem_mem_read), .ex_mem_mem_write(ex_mem_mem_write),
        .ex_mem_reg_write(ex_mem_reg_write), .ex_mem_reg_dest(ex_mem_reg_dest)
    );

    memory u_memory (
        .clk(clock), .arst_n(arst_n), .enable(enable),
        .ex_mem_result(ex_mem_result), .ex_mem_store_value(ex_mem_store_value),
        .ex_mem_mem_read(ex_mem_mem_read), .ex_mem_mem_write(ex_mem_mem_write),
        .ex_mem_reg_write(ex_mem_reg_write), .ex_mem_reg_dest(ex_mem_reg_dest),
        .ram_data_out(ram_data_out),
        .mem_addr(mem_addr), .mem_write_data(mem_write_data),
        .ram_write_enable(ram_write_enable), .pwm_write_enable(pwm_write_enable),
        .mem_wb_reg_write(mem_wb_reg_write), .mem_wb_reg_dest(mem_wb_reg_dest),
        .mem_wb_value(mem_wb_value)
    );

    register_bank u_register_bank (
        .clk(clock), .arst_n(arst_n), .enable(enable),
        .write_enable(mem_wb_reg_write), .write_address(mem_wb_reg_dest),
        .write_value(mem_wb_value),
        .read_address1(rb_read_address1), .read_address2(rb_read_address2),
        .value1(rb_value1), .value2(rb_value2), .led(led)
    );

    ram u_ram (
        .clk(clock), .enable(enable), .address(mem_addr), .data_in(mem_write_data),
        .write_enable(ram_write_enable), .data_out(ram_data_out)
    );

    pwm_peripheral u_pwm1 (
        .clk(clock), .arst_n(arst_n), .write_enable(pwm_write_enable),
        .duty_in(mem_write_data[PWM_W-1:0]), .pwm_out(port_pwm1)
    );

endmodule

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Test program for the ROM model, one word per instruction
localparam int PROGRAM_WORDS = 29;
localparam logic [31:0] PROGRAM [PROGRAM_WORDS] = '{
    32'h00500093,  // 0  addi x1, x0, 5
    32'h00C00113,  // 1  addi x2, x0, 12
    32'h00208FB3,  // 2  add  x31, x1, x2
    32'h401F8FB3,  // 3  sub  x31, x31, x1
    32'h001FCFB3,  // 4  xor  x31, x31, x1
    32'h002FEFB3,  // 5  or   x31, x31, x2
    32'h001FFFB3,  // 6  and  x31, x31, x1
    32'h002FAFB3,  // 7  slt  x31, x31, x2
    32'h028F8F93,  // 8  addi x31, x31, 40
    32'h01F02423,  // 9  sw   x31, 8(x0)
    32'h00802203,  // 10 lw   x4, 8(x0)
    32'h00220FB3,  // 11 add  x31, x4, x2   load-use
    32'h00108663,  // 12 beq  x1, x1, +12
    32'h03F00F93,  // 13 addi x31, x0, 63   skipped
    32'h03E00F93,  // 14 addi x31, x0, 62   skipped
    32'hFECF8F93,  // 15 addi x31, x31, -20
    32'h00209663,  // 16 bne  x1, x2, +12
    32'h03D00F93,  // 17 addi x31, x0, 61   skipped
    32'h03C00F93,  // 18 addi x31, x0, 60   skipped
    32'hFE2F8F93,  // 19 addi x31, x31, -30
    32'h40000293,  // 20 addi x5, x0, 1024
    32'h01300313,  // 21 addi x6, x0, 19
    32'h005282B3,  // 22 add  x5, x5, x5    doubling loop
    32'hFFF30313,  // 23 addi x6, x6, -1
    32'hFE031CE3,  // 24 bne  x6, x0, -8
    32'h04000393,  // 25 addi x7, x0, 64
    32'h0072A023,  // 26 sw   x7, 0(x5)     PWM duty
    32'h03000F93,  // 27 addi x31, x0, 48
    32'h00000063   // 28 beq  x0, x0, 0     park here
};

// Low six bits of x31 after each write, in program order
localparam int N_RESULTS = 11;
localparam logic [5:0] EXPECTED_LED [N_RESULTS] = '{
    6'd17, 6'd12, 6'd9, 6'd13, 6'd5, 6'd1, 6'd41, 6'd53, 6'd33, 6'd3, 6'd48
};

// Written only by the instructions that taken branches skip
localparam int N_WRONG_PATH = 4;
localparam logic [5:0] WRONG_PATH_LED [N_WRONG_PATH] = '{6'd63, 6'd62, 6'd61, 6'd60};

`endif

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_TIMEOUT  = 3000;  // Cycles for the whole program
    localparam int PWM_PERIOD   = 256;
    localparam int PWM_DUTY     = 64;
    localparam logic [XLEN-1:0] NOP = 32'h0000_0013;

    `include "tb_program.svh"

    logic                  clock;
    logic                  arst_n;
    logic                  enable;
    logic [XLEN-1:0]       rom_data;
    logic [ROM_ADDR_W-1:0] rom_address;
    logic [LED_W-1:0]      led;
    logic                  port_pwm1;

    // History of the last rising edge
    logic [LED_W-1:0]      prev_led;
    logic [ROM_ADDR_W-1:0] prev_rom_address;
    logic                  prev_enable;
    int                    led_index;  // Next expected result

    cpu u_cpu (
        .clock(clock), .arst_n(arst_n), .enable(enable), .rom_data(rom_data),
        .rom_address(rom_address), .led(led), .port_pwm1(port_pwm1)
    );

    // ROM model returns NOPs past the program end
    assign rom_data = (rom_address < PROGRAM_WORDS) ? PROGRAM[rom_address] : NOP;

    function automatic logic is_wrong_path_value(input logic [LED_W-1:0] value);
        int i;
        is_wrong_path_value = 1'b0;
        for (i = 0; i < N_WRONG_PATH; i++) begin
            if (WRONG_PATH_LED[i] == value)
                is_wrong_path_value = 1'b1;
        end
    endfunction

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] actual,
                                   input logic [XLEN-1:0] expected);
        $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        end_with_failure();
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prev_led         <= '0;
            prev_rom_address <= '0;
            prev_enable      <= 1'b1;
            led_index        <= 0;
        end else begin
            prev_led         <= led;
            prev_rom_address <= rom_address;
            prev_enable      <= enable;
            if (led != prev_led)
                led_index <= led_index + 1;
        end
    end

    // Reset state
    assert property (@(posedge clock) $rose(arst_n) |-> rom_address == '0)
        else report_mismatch("rom_address", $sampled(rom_address), 0);
    assert property (@(posedge clock) $rose(arst_n) |-> led == '0)
        else report_mismatch("led", $sampled(led), 0);
    assert property (@(posedge clock) disable iff (!arst_n) led_index == 0 |-> !port_pwm1)
        else report_mismatch("port_pwm1", $sampled(port_pwm1), 0);

    // x31 results appear in program order
    assert property (@(posedge clock) disable iff (!arst_n)
        led != prev_led |-> led_index < N_RESULTS)
        else report_error("led changed after the last expected result");
    assert property (@(posedge clock) disable iff (!arst_n)
        (led != prev_led && led_index < N_RESULTS) |-> led == EXPECTED_LED[led_index])
        else report_mismatch("led", $sampled(led), EXPECTED_LED[$sampled(led_index)]);
    assert property (@(posedge clock) disable iff (!arst_n) !is_wrong_path_value(led))
        else report_error($sformatf("led shows %0d from an instruction after a taken branch",
                                    $sampled(led)));

    // Nothing moves while enable is low
    assert property (@(posedge clock) disable iff (!arst_n)
        !prev_enable |-> rom_address == prev_rom_address)
        else report_mismatch("rom_address", $sampled(rom_address),
                             $sampled(prev_rom_address));
    assert property (@(posedge clock) disable iff (!arst_n)
        !prev_enable |-> led == prev_led)
        else report_mismatch("led", $sampled(led), $sampled(prev_led));

    initial begin
        int cycles;
        int low_cycles;
        int high_count;
        int period;
        int i;

        arst_n = 1'b0;
        enable = 1'b1;
        void'($urandom(17757));
        low_cycles = 0;
        repeat (RESET_CYCLES) @(negedge clock);
        arst_n = 1'b1;

        // Program run with random stretches of enable low
        cycles = 0;
        while (led_index < N_RESULTS) begin
            @(negedge clock);
            cycles++;
            if (cycles > RUN_TIMEOUT)
                report_error("timed out before led showed every expected result");
            if (low_cycles > 0) begin
                enable = 1'b0;
                low_cycles--;
            end else if ($urandom % 8 == 0) begin
                enable     = 1'b0;
                low_cycles = $urandom % 4;
            end else begin
                enable = 1'b1;
            end
        end

        // Duty store has retired by now
        enable = 1'b1;
        for (period = 0; period < 2; period++) begin
            high_count = 0;
            for (i = 0; i < PWM_PERIOD; i++) begin
                @(negedge clock);
                if (port_pwm1)
                    high_count++;
            end
            assert (high_count == PWM_DUTY)
                else report_mismatch("port_pwm1 high count", high_count, PWM_DUTY);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+testbench
common/cpu_pkg.sv
pipeline/fetch.sv
pipeline/decode.sv
pipeline/execute.sv
pipeline/memory.sv
hdl/register_bank.sv
hdl/ram.sv
hdl/pwm_peripheral.sv
hdl/cpu.sv
testbench/cpu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = cpu_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
